// File: build.f
+incdir+.
pmp_cfg_pkg.sv
pmp_bus_pkg.sv
pmp_axil_port.sv
pmp_csr_regs.sv
pmp_region_match.sv
pmp_priority_sel.sv
pmp_unit.sv
tb_pmp_unit.sv

// File: Bender.yml
package:
  name: pmp_unit

sources:
  - pmp_cfg_pkg.sv
  - pmp_bus_pkg.sv
  - pmp_axil_port.sv
  - pmp_csr_regs.sv
  - pmp_region_match.sv
  - pmp_priority_sel.sv
  - pmp_unit.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_pmp_unit.sv

// File: tb_pmp_model.svh
`ifndef TB_PMP_MODEL_SVH
`define TB_PMP_MODEL_SVH

logic [31:0] lfsr_q = 32'hd7b0;
pmp_cfg_t    m_cfg  [Regions];
pmp_addr_t   m_addr [Regions];
logic        m_mml, m_rlb;

// Galois LFSR, taps for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] rand_bits(int n);
  logic [31:0] r;
  r = '0;
  for (int i = 0; i < n; i++) begin
    lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
    r = {r[30:0], lfsr_q[0]};
  end
  return r;
endfunction

function automatic void model_reset();
  for (int i = 0; i < Regions; i++) begin
    m_cfg[i]  = '0;
    m_addr[i] = '0;
  end
  m_mml = 1'b0;
  m_rlb = 1'b0;
endfunction

function automatic reg_sel_e model_decode(axil_addr_t offs);
  if (offs[1:0] != 2'b00) return SelNone;
  if (offs[11:8] == 4'h0 && offs[7:2] < Regions / 4) return SelCfg;
  if (offs[11:8] == 4'h1 && offs[7:2] < Regions) return SelAddr;
  if (offs == 12'h200) return SelMseccfg;
  return SelNone;
endfunction

function automatic pmp_addr_t model_view(int i);
  pmp_addr_t low;
  low = (30'd1 << Gran) - 1;
  case (m_cfg[i][4:3])
    2'd3:    return m_addr[i] | low;
    2'd2:    return m_addr[i];
    default: return m_addr[i] & ~low;
  endcase
endfunction

function automatic axil_resp_t model_write(axil_addr_t offs, axil_data_t data);
  reg_sel_e   sel;
  int         w;
  pmp_cfg_t   old, nw, res;
  logic       locked;
  sel = model_decode(offs);
  w   = offs[7:2];
  if (sel == SelCfg) begin
    for (int j = 0; j < 4; j++) begin
      old = m_cfg[4*w+j];
      nw  = data[8*j +: 8];
      res = {nw[7], 2'b00, nw[4:0]};
      if (nw[1:0] == 2'b10 && !m_mml) res[2:0] = old[2:0];
      if (nw[4:3] == 2'd2 && Gran >= 1) res[4:3] = old[4:3];
      if (old[7] && !m_rlb) res = old;
      // Locked X-only, W-only, W+X or R+X refused under MML
      if (m_mml && !m_rlb && nw[7] && (nw[2:0] inside {3'b100, 3'b010, 3'b110, 3'b101})) begin
        res = old;
      end
      m_cfg[4*w+j] = res;
    end
  end else if (sel == SelAddr) begin
    locked = m_cfg[w][7];
    if (w + 1 < Regions && m_cfg[w+1][7] && m_cfg[w+1][4:3] == 2'd1) locked = 1'b1;
    if (!locked || m_rlb) m_addr[w] = data[29:0];
  end else if (sel == SelMseccfg) begin
    locked = 1'b0;
    for (int i = 0; i < Regions; i++) locked |= m_cfg[i][7];
    if (data[0]) m_mml = 1'b1;
    if (!locked || m_rlb) m_rlb = data[2];
  end
  return (sel == SelNone) ? RespSlvErr : RespOkay;
endfunction

function automatic axil_data_t model_rdata(axil_addr_t offs);
  int w;
  w = offs[7:2];
  case (model_decode(offs))
    SelCfg:     return {m_cfg[4*w+3], m_cfg[4*w+2], m_cfg[4*w+1], m_cfg[4*w]};
    SelAddr:    return {2'b00, model_view(w)};
    SelMseccfg: return {29'd0, m_rlb, 1'b0, m_mml};
    default:    return '0;
  endcase
endfunction

function automatic logic model_allow(phys_addr_t pa, pmp_acc_e acc, pmp_priv_e priv);
  pmp_addr_t   wa, lo, base;
  logic [31:0] mask;
  logic        hit;
  int          t;
  wa = pa[31:2];
  for (int i = 0; i < Regions; i++) begin
    hit = 1'b0;
    case (m_cfg[i][4:3])
      2'd1: begin
        lo  = (i == 0) ? '0 : (m_addr[i-1] & ~((30'd1 << Gran) - 1));
        hit = (wa >= lo) && (wa < model_view(i));
      end
      2'd2: hit = (wa == m_addr[i]);
      2'd3: begin
        base = model_view(i);
        t = 0;
        while (t < 30 && base[t]) t++;
        mask = 32'hffff_ffff << (t + 1);
        hit  = ((wa ^ base) & mask[29:0]) == '0;
      end
      default: hit = 1'b0;
    endcase
    if (hit) begin
      return ((priv == PrivMachine) && !m_cfg[i][7]) || m_cfg[i][acc];
    end
  end
  return priv == PrivMachine;
endfunction

`endif

// File: tb_pmp_unit.sv
`timescale 1ns/1ps

module tb_pmp_unit;
  import pmp_bus_pkg::*;
  import pmp_cfg_pkg::*;

  localparam int Regions    = 8;
  localparam int Gran       = 2;
  localparam int RandWrites = 60;
  localparam int LockRounds = 4;
  localparam int CheckRnds  = 6;
  localparam int ChecksPer  = 40;
  // Bus operations over all phases, each bounded in clock cycles
  localparam int TotalOps   = RandWrites * 2 + LockRounds * 40 + CheckRnds * (12 + ChecksPer)
                              + 80;
  localparam int CyclesPer  = 40;

  logic       clk_i, rst_ni;
  logic       awvalid_i, wvalid_i, bready_i, arvalid_i, rready_i, check_valid_i;
  axil_addr_t awaddr_i, araddr_i;
  axil_data_t wdata_i, rdata_o;
  logic       awready_o, wready_o, bvalid_o, arready_o, rvalid_o;
  axil_resp_t bresp_o, rresp_o;
  phys_addr_t check_addr_i;
  pmp_acc_e   check_acc_i;
  pmp_priv_e  check_priv_i;
  logic       result_valid_o, result_allow_o;
  logic [1:0] valid_hist;
  logic       exp_q [$];

  `include "tb_pmp_model.svh"

  pmp_unit #(
    .NumRegions  (Regions),
    .Granularity (Gran)
  ) i_pmp_unit (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic fail_run(string why);
    $display("** FAIL **");
    $fatal(1, "%s", why);
  endtask

  task automatic check_rdata(string name, axil_data_t got, axil_data_t exp);
    if (got !== exp) begin
      $display("** Error: %s = %h, expected %h", name, got, exp);
      fail_run("read data mismatch");
    end
  endtask

  task automatic check_resp(string name, axil_resp_t got, axil_resp_t exp);
    if (got !== exp) begin
      $display("** Error: %s = %h, expected %h", name, got, exp);
      fail_run("response mismatch");
    end
  endtask

  task automatic check_allow(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("** Error: %s = %h, expected %h", name, got, exp);
      fail_run("check result mismatch");
    end
  endtask

  initial begin
    #(TotalOps * CyclesPer * 8);
    fail_run("watchdog expired, the DUT stopped responding");
  end

  // Results must trail their requests by exactly two cycles
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      valid_hist = '0;
    end else begin
      check_allow("result_valid_o", result_valid_o, valid_hist[1]);
      if (result_valid_o) begin
        if (exp_q.size() == 0) fail_run("result arrived with no request pending");
        check_allow("result_allow_o", result_allow_o, exp_q.pop_front());
      end
      valid_hist = {valid_hist[0], check_valid_i};
    end
  end

  task automatic do_reset();
    @(posedge clk_i);
    rst_ni <= 1'b0;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    model_reset();
    @(negedge clk_i);
    if ({awready_o, wready_o, arready_o, bvalid_o, rvalid_o, result_valid_o} !== 6'b0) begin
      fail_run("handshake outputs were not low in the first cycle after reset");
    end
  endtask

  task automatic axi_write(axil_addr_t offs, axil_data_t data);
    int         wdly, bdly;
    logic       aw_hs, w_hs;
    bit         aw_done, w_done;
    axil_resp_t held, exp;
    wdly    = rand_bits(2);
    bdly    = rand_bits(3);
    aw_done = 0;
    w_done  = 0;
    @(posedge clk_i);
    awvalid_i <= 1'b1;
    awaddr_i  <= offs;
    if (wdly == 0) begin
      wvalid_i <= 1'b1;
      wdata_i  <= data;
    end
    while (!(aw_done && w_done)) begin
      @(negedge clk_i);
      aw_hs = awvalid_i && awready_o;
      w_hs  = wvalid_i && wready_o;
      @(posedge clk_i);
      if (aw_hs) begin
        awvalid_i <= 1'b0;
        aw_done = 1;
      end
      if (w_hs) begin
        wvalid_i <= 1'b0;
        w_done = 1;
      end
      if (wdly > 0) begin
        wdly--;
        if (wdly == 0) begin
          wvalid_i <= 1'b1;
          wdata_i  <= data;
        end
      end
    end
    do @(negedge clk_i); while (!bvalid_o);
    held = bresp_o;
    repeat (bdly) begin
      @(negedge clk_i);
      if (!bvalid_o) fail_run("bvalid_o dropped before bready_i");
      check_resp("bresp_o", bresp_o, held);
    end
    @(posedge clk_i);
    bready_i <= 1'b1;
    @(posedge clk_i);
    bready_i <= 1'b0;
    exp = model_write(offs, data);
    check_resp("bresp_o", held, exp);
  endtask

  task automatic axi_read(axil_addr_t offs);
    int         rdly;
    logic       ar_hs;
    axil_data_t held;
    axil_resp_t held_resp;
    rdly = rand_bits(3);
    @(posedge clk_i);
    arvalid_i <= 1'b1;
    araddr_i  <= offs;
    do begin
      @(negedge clk_i);
      ar_hs = arready_o;
      @(posedge clk_i);
    end while (!ar_hs);
    arvalid_i <= 1'b0;
    @(negedge clk_i);
    if (!rvalid_o) fail_run("rvalid_o did not rise one cycle after the read address");
    held      = rdata_o;
    held_resp = rresp_o;
    repeat (rdly) begin
      @(negedge clk_i);
      if (!rvalid_o) fail_run("rvalid_o dropped before rready_i");
      check_rdata("rdata_o", rdata_o, held);
      check_resp("rresp_o", rresp_o, held_resp);
    end
    @(posedge clk_i);
    rready_i <= 1'b1;
    @(posedge clk_i);
    rready_i <= 1'b0;
    check_rdata("rdata_o", held, model_rdata(offs));
    check_resp("rresp_o", held_resp, (model_decode(offs) == SelNone) ? RespSlvErr : RespOkay);
  endtask

  task automatic read_all();
    for (int w = 0; w < Regions / 4; w++) axi_read(axil_addr_t'(4 * w));
    for (int i = 0; i < Regions; i++) axi_read(axil_addr_t'(12'h100 + 4 * i));
    axi_read(12'h200);
  endtask

  task automatic random_setup(bit with_locks);
    axil_data_t mask;
    mask = with_locks ? 32'hffff_ffff : 32'h7f7f_7f7f;
    for (int i = 0; i < Regions; i++) axi_write(axil_addr_t'(12'h100 + 4 * i), rand_bits(8));
    for (int w = 0; w < Regions / 4; w++) axi_write(axil_addr_t'(4 * w), rand_bits(32) & mask);
  endtask

  task automatic run_checks(int n);
    phys_addr_t pa;
    pmp_acc_e   acc;
    pmp_priv_e  priv;
    for (int k = 0; k < n; k++) begin
      pa   = phys_addr_t'(rand_bits(10));
      acc  = (rand_bits(2) == 0) ? AccRead : (rand_bits(1) ? AccWrite : AccExec);
      priv = rand_bits(1) ? PrivMachine : PrivUser;
      @(posedge clk_i);
      check_valid_i <= 1'b1;
      check_addr_i  <= pa;
      check_acc_i   <= acc;
      check_priv_i  <= priv;
      exp_q.push_back(model_allow(pa, acc, priv));
    end
    @(posedge clk_i);
    check_valid_i <= 1'b0;
    repeat (4) @(posedge clk_i);
    if (exp_q.size() != 0) fail_run("check results went missing");
  endtask

  initial begin
    axil_addr_t offs;
    rst_ni        = 1'b0;
    awvalid_i     = 1'b0;
    awaddr_i      = '0;
    wvalid_i      = 1'b0;
    wdata_i       = '0;
    bready_i      = 1'b0;
    arvalid_i     = 1'b0;
    araddr_i      = '0;
    rready_i      = 1'b0;
    check_valid_i = 1'b0;
    check_addr_i  = '0;
    check_acc_i   = AccRead;
    check_priv_i  = PrivUser;
    do_reset();

    // Legalization of unlocked writes, each read back at once
    for (int k = 0; k < RandWrites; k++) begin
      if (rand_bits(1)) begin
        offs = axil_addr_t'(4 * rand_bits(1));
        axi_write(offs, rand_bits(32) & 32'h7f7f_7f7f);
      end else begin
        offs = axil_addr_t'(12'h100 + 4 * rand_bits(3));
        axi_write(offs, rand_bits(32));
      end
      axi_read(offs);
    end
    read_all();

    // Locked entries, first without and then with RLB set beforehand
    for (int r = 0; r < LockRounds; r++) begin
      do_reset();
      if (r % 2) axi_write(12'h200, 32'h4);
      random_setup(1'b1);
      for (int w = 0; w < Regions / 4; w++) axi_write(axil_addr_t'(4 * w), rand_bits(32));
      for (int i = 0; i < Regions; i++) axi_write(axil_addr_t'(12'h100 + 4 * i), rand_bits(32));
      read_all();
    end

    // MML stickiness, RLB refusal, locked-executable refusal
    do_reset();
    axi_write(12'h200, 32'h1);
    axi_write(12'h200, 32'h0);
    axi_read(12'h200);
    axi_write(12'h000, 32'h9c8d_8a81);
    axi_write(12'h004, 32'h8f8b_0b99);
    axi_write(12'h200, 32'h5);
    read_all();

    // Access checks over random configurations
    for (int r = 0; r < CheckRnds; r++) begin
      do_reset();
      random_setup(r >= CheckRnds / 2);
      run_checks(ChecksPer);
    end

    // Unmapped offsets
    do_reset();
    random_setup(1'b0);
    axi_write(12'h008, rand_bits(32));
    axi_write(12'h120, rand_bits(32));
    axi_write(12'h102, rand_bits(32));
    axi_write(12'h300, rand_bits(32));
    axi_read(12'h204);
    axi_read(12'h00c);
    axi_read(12'hffc);
    read_all();

    if (exp_q.size() == 0) begin
      $display("** PASS **");
      $finish;
    end else begin
      fail_run("check results left over at the end");
    end
  end

endmodule

// File: pmp_unit.sv
`timescale 1ns/1ps

module pmp_unit #(
  parameter int NumRegions  = 8,
  parameter int Granularity = 2
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    awvalid_i,
  output logic                    awready_o,
  input  pmp_bus_pkg::axil_addr_t awaddr_i,
  input  logic                    wvalid_i,
  output logic                    wready_o,
  input  pmp_bus_pkg::axil_data_t wdata_i,
  output logic                    bvalid_o,
  input  logic                    bready_i,
  output pmp_bus_pkg::axil_resp_t bresp_o,
  input  logic                    arvalid_i,
  output logic                    arready_o,
  input  pmp_bus_pkg::axil_addr_t araddr_i,
  output logic                    rvalid_o,
  input  logic                    rready_i,
  output pmp_bus_pkg::axil_data_t rdata_o,
  output pmp_bus_pkg::axil_resp_t rresp_o,
  input  logic                    check_valid_i,
  input  pmp_bus_pkg::phys_addr_t check_addr_i,
  input  pmp_bus_pkg::pmp_acc_e   check_acc_i,
  input  pmp_bus_pkg::pmp_priv_e  check_priv_i,
  output logic                    result_valid_o,
  output logic                    result_allow_o
);
  import pmp_bus_pkg::*;
  import pmp_cfg_pkg::*;

  logic                            wr_en, rd_err;
  reg_sel_e                        wr_sel, rd_sel;
  logic [$clog2(NumRegions)-1:0]   wr_idx, rd_idx;
  axil_data_t                      wr_data, rd_data;
  pmp_cfg_t  [NumRegions-1:0]      cfg;
  pmp_addr_t [NumRegions-1:0]      addr;
  logic      [NumRegions-1:0]      match, perm, lock;

  pmp_axil_port #(
    .NumRegions (NumRegions)
  ) i_axil_port (
    .clk_i, .rst_ni,
    .awvalid_i, .awready_o, .awaddr_i,
    .wvalid_i, .wready_o, .wdata_i,
    .bvalid_o, .bready_i, .bresp_o,
    .arvalid_i, .arready_o, .araddr_i,
    .rvalid_o, .rready_i, .rdata_o, .rresp_o,
    .wr_en_o   (wr_en),
    .wr_sel_o  (wr_sel),
    .wr_idx_o  (wr_idx),
    .wr_data_o (wr_data),
    .rd_sel_o  (rd_sel),
    .rd_idx_o  (rd_idx),
    .rd_data_i (rd_data),
    .rd_err_i  (rd_err)
  );

  // MML only shapes write legality, so its flag is left for debug
  pmp_csr_regs #(
    .NumRegions  (NumRegions),
    .Granularity (Granularity)
  ) i_csr_regs (
    .clk_i, .rst_ni,
    .wr_en_i   (wr_en),
    .wr_sel_i  (wr_sel),
    .wr_idx_i  (wr_idx),
    .wr_data_i (wr_data),
    .rd_sel_i  (rd_sel),
    .rd_idx_i  (rd_idx),
    .rd_data_o (rd_data),
    .rd_err_o  (rd_err),
    .cfg_o     (cfg),
    .addr_o    (addr),
    .mml_o     ()
  );

  for (genvar i = 0; i < NumRegions; i++) begin : gen_region
    pmp_addr_t prev_addr;

    if (i == 0) begin : gen_first
      assign prev_addr = '0;
    end else begin : gen_chain
      assign prev_addr = addr[i-1];
    end

    pmp_region_match #(
      .Granularity (Granularity)
    ) i_region_match (
      .clk_i, .rst_ni,
      .check_addr_i,
      .check_acc_i,
      .cfg_i       (cfg[i]),
      .addr_i      (addr[i]),
      .prev_addr_i (prev_addr),
      .match_o     (match[i]),
      .perm_o      (perm[i]),
      .lock_o      (lock[i])
    );
  end

  pmp_priority_sel #(
    .NumRegions (NumRegions)
  ) i_priority_sel (
    .clk_i, .rst_ni,
    .check_valid_i,
    .check_priv_i,
    .match_i (match),
    .perm_i  (perm),
    .lock_i  (lock),
    .result_valid_o,
    .result_allow_o
  );

endmodule

// File: pmp_priority_sel.sv
`timescale 1ns/1ps

module pmp_priority_sel #(
  parameter int NumRegions = 8
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   check_valid_i,
  input  pmp_bus_pkg::pmp_priv_e check_priv_i,
  input  logic [NumRegions-1:0]  match_i,
  input  logic [NumRegions-1:0]  perm_i,
  input  logic [NumRegions-1:0]  lock_i,
  output logic                   result_valid_o,
  output logic                   result_allow_o
);
  import pmp_bus_pkg::*;

  logic      valid_q, result_valid_q, result_allow_q, allow;
  pmp_priv_e priv_q;

  // Walk from the top so the lowest matching region decides
  always_comb begin
    allow = (priv_q == PrivMachine);
    for (int i = NumRegions - 1; i >= 0; i--) begin
      if (match_i[i]) begin
        allow = ((priv_q == PrivMachine) && !lock_i[i]) || perm_i[i];
      end
    end
  end

  // Valid and priv follow the matcher stage, then the result stage
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q        <= 1'b0;
      priv_q         <= PrivUser;
      result_valid_q <= 1'b0;
      result_allow_q <= 1'b0;
    end else begin
      valid_q        <= check_valid_i;
      priv_q         <= check_priv_i;
      result_valid_q <= valid_q;
      result_allow_q <= allow;
    end
  end

  assign result_valid_o = result_valid_q;
  assign result_allow_o = result_allow_q;

endmodule

// File: pmp_region_match.sv
`timescale 1ns/1ps

module pmp_region_match #(
  parameter int Granularity = 2
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  pmp_bus_pkg::phys_addr_t check_addr_i,
  input  pmp_bus_pkg::pmp_acc_e   check_acc_i,
  input  pmp_cfg_pkg::pmp_cfg_t   cfg_i,
  input  pmp_cfg_pkg::pmp_addr_t  addr_i,
  input  pmp_cfg_pkg::pmp_addr_t  prev_addr_i,
  output logic                    match_o,
  output logic                    perm_o,
  output logic                    lock_o
);
  import pmp_bus_pkg::*;
  import pmp_cfg_pkg::*;

  pmp_mode_e mode;
  pmp_addr_t word, top, bottom, napot_ign;
  logic      hit, perm;
  logic      match_q, perm_q, lock_q;

  assign mode   = cfg_mode(cfg_i);
  assign word   = check_addr_i[31:2];
  assign top    = gran_view(addr_i, mode, Granularity);
  // Bottom of a TOR range is grain aligned whatever the mode below
  assign bottom = gran_view(prev_addr_i, ModeTor, Granularity);

  // Trailing ones plus the first zero give the don't-care bits
  assign napot_ign = top ^ (top + 1'b1);

  always_comb begin
    unique case (mode)
      ModeTor:   hit = (word >= bottom) && (word < top);
      ModeNa4:   hit = (word == addr_i);
      ModeNapot: hit = ((word ^ top) & ~napot_ign) == '0;
      default:   hit = 1'b0;
    endcase
  end

  always_comb begin
    unique case (check_acc_i)
      AccRead:  perm = cfg_i[CfgReadBit];
      AccWrite: perm = cfg_i[CfgWriteBit];
      AccExec:  perm = cfg_i[CfgExecBit];
      default:  perm = 1'b0;
    endcase
  end

  // Stage 1
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      match_q <= 1'b0;
      perm_q  <= 1'b0;
      lock_q  <= 1'b0;
    end else begin
      match_q <= hit;
      perm_q  <= perm;
      lock_q  <= cfg_i[CfgLockBit];
    end
  end

  assign match_o = match_q;
  assign perm_o  = perm_q;
  assign lock_o  = lock_q;

  a_off_no_match: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mode == ModeOff |=> !match_o);

endmodule

// File: pmp_csr_regs.sv
`timescale 1ns/1ps

module pmp_csr_regs #(
  parameter int NumRegions  = 8,
  parameter int Granularity = 2
) (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  input  logic                                        wr_en_i,
  input  pmp_bus_pkg::reg_sel_e                       wr_sel_i,
  input  logic [$clog2(NumRegions)-1:0]               wr_idx_i,
  input  pmp_bus_pkg::axil_data_t                     wr_data_i,
  input  pmp_bus_pkg::reg_sel_e                       rd_sel_i,
  input  logic [$clog2(NumRegions)-1:0]               rd_idx_i,
  output pmp_bus_pkg::axil_data_t                     rd_data_o,
  output logic                                        rd_err_o,
  output pmp_cfg_pkg::pmp_cfg_t  [NumRegions-1:0]     cfg_o,
  output pmp_cfg_pkg::pmp_addr_t [NumRegions-1:0]     addr_o,
  output logic                                        mml_o
);
  import pmp_bus_pkg::*;
  import pmp_cfg_pkg::*;

  pmp_cfg_t  [NumRegions-1:0] cfg_q;
  pmp_addr_t [NumRegions-1:0] addr_q;
  logic                       mml_q, rlb_q;
  logic      [NumRegions-1:0] lock_vec, tor_lock_vec, addr_lock;
  logic                       any_locked;
  mseccfg_t                   mseccfg_rd;

  // WARL rules for one cfg byte, judged against the state before the write
  function automatic pmp_cfg_t legal_cfg(pmp_cfg_t old_cfg, pmp_cfg_t new_cfg,
                                         logic mml, logic rlb);
    pmp_cfg_t   res;
    logic [3:0] lrwx;
    res  = new_cfg & CfgZeroMask;
    lrwx = {new_cfg[CfgLockBit], new_cfg[CfgReadBit], new_cfg[CfgWriteBit],
            new_cfg[CfgExecBit]};
    // W without R is reserved outside MML
    if (new_cfg[CfgWriteBit] && !new_cfg[CfgReadBit] && !mml) begin
      res[2:0] = old_cfg[2:0];
    end
    // NA4 is not selectable with a grain above 4 bytes
    if (Granularity >= 1 && cfg_mode(new_cfg) == ModeNa4) begin
      res[4:3] = old_cfg[4:3];
    end
    if (old_cfg[CfgLockBit] && !rlb) begin
      res = old_cfg;
    end
    // Locked executable encodings are refused under MML
    if (mml && !rlb && (lrwx inside {4'b1001, 4'b1010, 4'b1011, 4'b1101})) begin
      res = old_cfg;
    end
    return res;
  endfunction

  always_comb begin
    for (int i = 0; i < NumRegions; i++) begin
      lock_vec[i]     = cfg_q[i][CfgLockBit];
      tor_lock_vec[i] = cfg_q[i][CfgLockBit] && (cfg_mode(cfg_q[i]) == ModeTor);
    end
  end

  // A locked TOR entry also guards the pmpaddr below it
  assign addr_lock  = rlb_q ? '0 : (lock_vec | (tor_lock_vec >> 1));
  assign any_locked = |lock_vec;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q  <= '0;
      addr_q <= '0;
      mml_q  <= 1'b0;
      rlb_q  <= 1'b0;
    end else if (wr_en_i) begin
      for (int i = 0; i < NumRegions; i++) begin
        if (wr_sel_i == SelCfg && wr_idx_i == i / 4) begin
          cfg_q[i] <= legal_cfg(cfg_q[i], wr_data_i[8*(i%4) +: 8], mml_q, rlb_q);
        end
        if (wr_sel_i == SelAddr && wr_idx_i == i && !addr_lock[i]) begin
          addr_q[i] <= wr_data_i[29:0];
        end
      end
      if (wr_sel_i == SelMseccfg) begin
        // MML is sticky until reset
        mml_q <= mml_q | wr_data_i[MseccfgMmlBit];
        if (!(any_locked && !rlb_q)) begin
          rlb_q <= wr_data_i[MseccfgRlbBit];
        end
      end
    end
  end

  always_comb begin
    mseccfg_rd                = '0;
    mseccfg_rd[MseccfgMmlBit] = mml_q;
    mseccfg_rd[MseccfgRlbBit] = rlb_q;
  end

  always_comb begin
    rd_data_o = '0;
    rd_err_o  = 1'b0;
    unique case (rd_sel_i)
      SelCfg: begin
        if (rd_idx_i < NumRegions / 4) begin
          for (int j = 0; j < 4; j++) begin
            rd_data_o[8*j +: 8] = cfg_q[4*rd_idx_i + j];
          end
        end else begin
          rd_err_o = 1'b1;
        end
      end
      SelAddr: begin
        if (rd_idx_i < NumRegions) begin
          rd_data_o = {2'b00, gran_view(addr_q[rd_idx_i], cfg_mode(cfg_q[rd_idx_i]),
                                        Granularity)};
        end else begin
          rd_err_o = 1'b1;
        end
      end
      SelMseccfg: rd_data_o = mseccfg_rd;
      default:    rd_err_o  = 1'b1;
    endcase
  end

  assign cfg_o  = cfg_q;
  assign addr_o = addr_q;
  assign mml_o  = mml_q;

  // Locks only fall away through RLB or reset
  a_lock_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !rlb_q |=> ($past(lock_vec) & ~lock_vec) == '0);

endmodule

// File: pmp_axil_port.sv
`timescale 1ns/1ps

module pmp_axil_port #(
  parameter int NumRegions = 8
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              awvalid_i,
  output logic                              awready_o,
  input  pmp_bus_pkg::axil_addr_t           awaddr_i,
  input  logic                              wvalid_i,
  output logic                              wready_o,
  input  pmp_bus_pkg::axil_data_t           wdata_i,
  output logic                              bvalid_o,
  input  logic                              bready_i,
  output pmp_bus_pkg::axil_resp_t           bresp_o,
  input  logic                              arvalid_i,
  output logic                              arready_o,
  input  pmp_bus_pkg::axil_addr_t           araddr_i,
  output logic                              rvalid_o,
  input  logic                              rready_i,
  output pmp_bus_pkg::axil_data_t           rdata_o,
  output pmp_bus_pkg::axil_resp_t           rresp_o,
  output logic                              wr_en_o,
  output pmp_bus_pkg::reg_sel_e             wr_sel_o,
  output logic [$clog2(NumRegions)-1:0]     wr_idx_o,
  output pmp_bus_pkg::axil_data_t           wr_data_o,
  output pmp_bus_pkg::reg_sel_e             rd_sel_o,
  output logic [$clog2(NumRegions)-1:0]     rd_idx_o,
  input  pmp_bus_pkg::axil_data_t           rd_data_i,
  input  logic                              rd_err_i
);
  import pmp_bus_pkg::*;

  localparam int IdxW = $clog2(NumRegions);

  typedef enum logic [1:0] {WrIdle, WrHaveAddr, WrHaveData, WrResp} wr_state_e;
  typedef enum logic {RdIdle, RdResp} rd_state_e;

  wr_state_e  wr_state_q, wr_state_d;
  rd_state_e  rd_state_q, rd_state_d;
  logic       awready_q, wready_q, arready_q;
  logic       aw_hs, w_hs, ar_hs, wr_fire;
  axil_addr_t awaddr_q, wr_addr;
  axil_data_t wdata_q, rdata_q;
  axil_resp_t bresp_q, rresp_q;

  // Map an offset to a register kind, word aligned and in range only
  function automatic reg_sel_e decode_sel(axil_addr_t offs);
    logic [5:0] word;
    word = offs[7:2];
    if (offs[1:0] != 2'b00) begin
      return SelNone;
    end
    if ((offs & 12'hf00) == CfgBase && word < NumRegions / 4) begin
      return SelCfg;
    end
    if ((offs & 12'hf00) == AddrBase && word < NumRegions) begin
      return SelAddr;
    end
    if (offs == MseccfgOffs) begin
      return SelMseccfg;
    end
    return SelNone;
  endfunction

  assign aw_hs = awvalid_i && awready_o;
  assign w_hs  = wvalid_i && wready_o;
  assign ar_hs = arvalid_i && arready_o;

  // AW and W may arrive in either order
  always_comb begin
    wr_state_d = wr_state_q;
    wr_fire    = 1'b0;
    unique case (wr_state_q)
      WrIdle: begin
        if (aw_hs && w_hs) begin
          wr_fire    = 1'b1;
          wr_state_d = WrResp;
        end else if (aw_hs) begin
          wr_state_d = WrHaveAddr;
        end else if (w_hs) begin
          wr_state_d = WrHaveData;
        end
      end
      WrHaveAddr: begin
        if (w_hs) begin
          wr_fire    = 1'b1;
          wr_state_d = WrResp;
        end
      end
      WrHaveData: begin
        if (aw_hs) begin
          wr_fire    = 1'b1;
          wr_state_d = WrResp;
        end
      end
      WrResp: begin
        if (bready_i) begin
          wr_state_d = WrIdle;
        end
      end
      default: wr_state_d = WrIdle;
    endcase
  end

  always_comb begin
    rd_state_d = rd_state_q;
    unique case (rd_state_q)
      RdIdle: begin
        if (ar_hs) begin
          rd_state_d = RdResp;
        end
      end
      RdResp: begin
        if (rready_i) begin
          rd_state_d = RdIdle;
        end
      end
      default: rd_state_d = RdIdle;
    endcase
  end

  // Readies are registered so they stay low in the first cycle after reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_state_q <= WrIdle;
      rd_state_q <= RdIdle;
      awready_q  <= 1'b0;
      wready_q   <= 1'b0;
      arready_q  <= 1'b0;
    end else begin
      wr_state_q <= wr_state_d;
      rd_state_q <= rd_state_d;
      awready_q  <= (wr_state_d == WrIdle) || (wr_state_d == WrHaveData);
      wready_q   <= (wr_state_d == WrIdle) || (wr_state_d == WrHaveAddr);
      arready_q  <= (rd_state_d == RdIdle);
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      awaddr_q <= awaddr_i;
    end
    if (w_hs) begin
      wdata_q <= wdata_i;
    end
    if (wr_fire) begin
      bresp_q <= (wr_sel_o == SelNone) ? RespSlvErr : RespOkay;
    end
    if (ar_hs) begin
      rdata_q <= rd_err_i ? '0 : rd_data_i;
      rresp_q <= rd_err_i ? RespSlvErr : RespOkay;
    end
  end

  // Write strobe on the edge that raises bvalid_o
  assign wr_addr   = (wr_state_q == WrHaveAddr) ? awaddr_q : awaddr_i;
  assign wr_sel_o  = decode_sel(wr_addr);
  assign wr_idx_o  = wr_addr[IdxW+1:2];
  assign wr_data_o = (wr_state_q == WrHaveData) ? wdata_q : wdata_i;
  assign wr_en_o   = wr_fire && (wr_sel_o != SelNone);

  assign rd_sel_o = decode_sel(araddr_i);
  assign rd_idx_o = araddr_i[IdxW+1:2];

  assign awready_o = awready_q;
  assign wready_o  = wready_q;
  assign arready_o = arready_q;
  assign bvalid_o  = (wr_state_q == WrResp);
  assign bresp_o   = bresp_q;
  assign rvalid_o  = (rd_state_q == RdResp);
  assign rdata_o   = rdata_q;
  assign rresp_o   = rresp_q;

  a_bvalid_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bvalid_o && !bready_i |=> bvalid_o && $stable(bresp_o));

  a_rvalid_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o) && $stable(rresp_o));

endmodule

// File: pmp_bus_pkg.sv
package pmp_bus_pkg;

  typedef logic [11:0] axil_addr_t;
  typedef logic [31:0] axil_data_t;
  typedef logic [1:0]  axil_resp_t;

  localparam axil_resp_t RespOkay   = 2'b00;
  localparam axil_resp_t RespSlvErr = 2'b10;

  // Register map, one 256-byte block per register kind
  localparam axil_addr_t CfgBase     = 12'h000;
  localparam axil_addr_t AddrBase    = 12'h100;
  localparam axil_addr_t MseccfgOffs = 12'h200;

  typedef logic [31:0] phys_addr_t;

  typedef enum logic [1:0] {
    PrivUser    = 2'd0,
    PrivMachine = 2'd3
  } pmp_priv_e;

  typedef enum logic [1:0] {
    AccRead  = 2'd0,
    AccWrite = 2'd1,
    AccExec  = 2'd2
  } pmp_acc_e;

  typedef enum logic [1:0] {
    SelCfg     = 2'd0,
    SelAddr    = 2'd1,
    SelMseccfg = 2'd2,
    SelNone    = 2'd3
  } reg_sel_e;

endpackage

// File: pmp_cfg_pkg.sv
package pmp_cfg_pkg;

  // One pmpNcfg byte laid out as {L, 2'b00, A[1:0], X, W, R}
  typedef logic [7:0] pmp_cfg_t;

  typedef enum logic [1:0] {
    ModeOff   = 2'd0,
    ModeTor   = 2'd1,
    ModeNa4   = 2'd2,
    ModeNapot = 2'd3
  } pmp_mode_e;

  // Stored pmpaddr, physical address bits 31:2
  typedef logic [29:0] pmp_addr_t;

  typedef logic [31:0] mseccfg_t;

  localparam int MseccfgMmlBit = 0;
  localparam int MseccfgRlbBit = 2;

  localparam int CfgLockBit  = 7;
  localparam int CfgExecBit  = 2;
  localparam int CfgWriteBit = 1;
  localparam int CfgReadBit  = 0;

  // Bits 6:5 are hardwired to zero
  localparam pmp_cfg_t CfgZeroMask = 8'h9f;

  function automatic pmp_mode_e cfg_mode(pmp_cfg_t cfg);
    return pmp_mode_e'(cfg[4:3]);
  endfunction

  // Address as seen with a grain of 2^(G+2) bytes
  function automatic pmp_addr_t gran_view(pmp_addr_t addr, pmp_mode_e mode, int unsigned gran);
    pmp_addr_t low;
    low = ~(pmp_addr_t'('1) << gran);
    if (mode == ModeNapot) begin
      return addr | low;
    end else if (mode == ModeNa4) begin
      return addr;
    end
    return addr & ~low;
  endfunction

endpackage
